//--- build.f
+incdir+include
source/mrd_dft_pkg.sv
source/mrd_dft_cfg.sv
source/mrd_dft_rdx2.sv
source/mrd_dft_rdx3.sv
source/mrd_dft_rdx4.sv
source/mrd_dft_core.sv
source/mrd_dft_top.sv
tests/mrd_dft_tb.sv

//--- include/mrd_dft_macros.svh
`ifndef MRD_DFT_MACROS_SVH
`define MRD_DFT_MACROS_SVH

// sample part width and radix-3 product width
`define MRD_W_DATA 30
`define MRD_W_TEMP 48

// complex lanes per vector
`define MRD_LANES 5

// sin(60 deg) in Q14, and the shift that drops the fraction
`define MRD_C3_Q14 14189
`define MRD_C3_SHIFT 14

// cycles through each butterfly kernel
`define MRD_KERNEL_LAT 3

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module mrd_dft_tb \
	-o mrd_dft_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mrd_dft_sim > sim.log 2>&1 ; cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; } \
	|| { echo "no failure reported"; exit 0; }

//--- source/mrd_dft_cfg.sv
module mrd_dft_cfg import mrd_dft_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   cfg_wr,
	input  radix_t cfg_radix,
	input  logic   pipe_empty,
	output radix_t radix
);

	logic   pend;
	radix_t pend_radix;

	// a write on this cycle overrides anything still waiting
	logic   req;
	radix_t req_radix;

	assign req       = cfg_wr | pend;
	assign req_radix = cfg_wr ? cfg_radix : pend_radix;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			radix      <= RDX_3;
			pend       <= 1'b0;
			pend_radix <= RDX_3;
		end else begin
			if (cfg_wr) begin
				pend_radix <= cfg_radix;
			end
			if (pipe_empty) begin
				// nothing in flight, safe to switch kernels
				if (req) begin
					radix <= req_radix;
				end
				pend <= 1'b0;
			end else begin
				pend <= req;
			end
		end
	end

endmodule

//--- source/mrd_dft_core.sv
`include "mrd_dft_macros.svh"

module mrd_dft_core import mrd_dft_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  radix_t    radix,
	input  logic      in_val,
	input  cplx_vec_t din,
	output logic      out_val,
	output cplx_vec_t dout,
	output logic      pipe_empty
);

	localparam int w_infl = $clog2(`MRD_KERNEL_LAT + 1);

	logic      k2_val;
	logic      k3_val;
	logic      k4_val;
	cplx_vec_t k2_dout;
	cplx_vec_t k3_dout;
	cplx_vec_t k4_dout;

	logic      sel_val;
	cplx_vec_t sel_dout;

	// vectors currently inside the kernels
	logic [w_infl-1:0] infl;

	// all kernels run in parallel on the same stream
	mrd_dft_rdx2 u_rdx2 (
		.clk(clk), .rst_n(rst_n), .in_val(in_val), .din(din),
		.out_val(k2_val), .dout(k2_dout)
	);

	mrd_dft_rdx3 u_rdx3 (
		.clk(clk), .rst_n(rst_n), .in_val(in_val), .din(din),
		.out_val(k3_val), .dout(k3_dout)
	);

	mrd_dft_rdx4 u_rdx4 (
		.clk(clk), .rst_n(rst_n), .in_val(in_val), .din(din),
		.out_val(k4_val), .dout(k4_dout)
	);

	always_comb begin
		case (radix)
			RDX_2: begin
				sel_val  = k2_val;
				sel_dout = k2_dout;
			end
			RDX_4: begin
				sel_val  = k4_val;
				sel_dout = k4_dout;
			end
			default: begin
				sel_val  = k3_val;
				sel_dout = k3_dout;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
			dout    <= '0;
			infl    <= '0;
		end else begin
			out_val <= sel_val;
			if (sel_val) begin
				dout <= sel_dout;
			end
			// one in per in_val, one out per kernel valid
			infl <= infl + w_infl'(in_val) - w_infl'(k3_val);
		end
	end

	assign pipe_empty = !in_val && (infl == '0) && !out_val;

endmodule

//--- source/mrd_dft_pkg.sv
`include "mrd_dft_macros.svh"

package mrd_dft_pkg;

	// one complex sample, real part in the upper half
	typedef struct packed {
		logic signed [`MRD_W_DATA-1:0] re;
		logic signed [`MRD_W_DATA-1:0] im;
	} cplx_t;

	// lane 0 is the leftmost element
	typedef cplx_t [0:`MRD_LANES-1] cplx_vec_t;

	// kernel selection
	typedef enum logic [1:0] {
		RDX_2 = 2'd0,
		RDX_3 = 2'd1,
		RDX_4 = 2'd2
	} radix_t;

endpackage

//--- source/mrd_dft_rdx2.sv
`include "mrd_dft_macros.svh"

module mrd_dft_rdx2 import mrd_dft_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  cplx_vec_t din,
	output logic      out_val,
	output cplx_vec_t dout
);

	logic [1:0] val_r;

	cplx_t s1_sum;
	cplx_t s1_dif;
	cplx_t s2_sum;
	cplx_t s2_dif;

	// valid tracking, one bit per stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_r   <= 2'b00;
			out_val <= 1'b0;
		end else begin
			val_r[0] <= in_val;
			val_r[1] <= val_r[0];
			out_val  <= val_r[1];
		end
	end

	always_ff @(posedge clk) begin
		// stage 1: the butterfly itself
		s1_sum.re <= din[0].re + din[1].re;
		s1_sum.im <= din[0].im + din[1].im;
		s1_dif.re <= din[0].re - din[1].re;
		s1_dif.im <= din[0].im - din[1].im;

		// stage 2: delay only, keeps latency equal to the other kernels
		s2_sum <= s1_sum;
		s2_dif <= s1_dif;

		// stage 3
		dout[0] <= s2_sum;
		dout[1] <= s2_dif;
		for (int i = 2; i < `MRD_LANES; i++) begin
			dout[i] <= '0;
		end
	end

endmodule

//--- source/mrd_dft_rdx3.sv
`include "mrd_dft_macros.svh"

module mrd_dft_rdx3 import mrd_dft_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  cplx_vec_t din,
	output logic      out_val,
	output cplx_vec_t dout
);

	localparam logic signed [`MRD_W_TEMP-1:0] c3_pos = `MRD_C3_Q14;
	localparam logic signed [`MRD_W_TEMP-1:0] c3_neg = -`MRD_C3_Q14;

	logic [1:0] val_r;

	// stage 1
	cplx_t s1_a;
	cplx_t s1_s;
	cplx_t s1_t;

	// stage 2
	cplx_t s2_x0;
	cplx_t s2_m;
	logic signed [`MRD_W_TEMP-1:0] s2_prod_re;
	logic signed [`MRD_W_TEMP-1:0] s2_prod_im;

	// truncated rotation term
	logic signed [`MRD_W_TEMP-1:0] prod_re_sh;
	logic signed [`MRD_W_TEMP-1:0] prod_im_sh;
	cplx_t rot;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_r   <= 2'b00;
			out_val <= 1'b0;
		end else begin
			val_r[0] <= in_val;
			val_r[1] <= val_r[0];
			out_val  <= val_r[1];
		end
	end

	always_ff @(posedge clk) begin
		// stage 1: s = b + c, t = c - b
		s1_a      <= din[0];
		s1_s.re   <= din[1].re + din[2].re;
		s1_s.im   <= din[1].im + din[2].im;
		s1_t.re   <= din[2].re - din[1].re;
		s1_t.im   <= din[2].im - din[1].im;

		// stage 2: half of s truncates toward zero
		s2_x0.re  <= s1_a.re + s1_s.re;
		s2_x0.im  <= s1_a.im + s1_s.im;
		s2_m.re   <= s1_a.re - s1_s.re / 2;
		s2_m.im   <= s1_a.im - s1_s.im / 2;

		// j * sin60 * t, still in Q14
		s2_prod_re <= s1_t.im * c3_neg;
		s2_prod_im <= s1_t.re * c3_pos;
	end

	assign prod_re_sh = s2_prod_re >>> `MRD_C3_SHIFT;
	assign prod_im_sh = s2_prod_im >>> `MRD_C3_SHIFT;
	assign rot.re     = prod_re_sh[`MRD_W_DATA-1:0];
	assign rot.im     = prod_im_sh[`MRD_W_DATA-1:0];

	always_ff @(posedge clk) begin
		// stage 3
		dout[0]    <= s2_x0;
		dout[1].re <= s2_m.re + rot.re;
		dout[1].im <= s2_m.im + rot.im;
		dout[2].re <= s2_m.re - rot.re;
		dout[2].im <= s2_m.im - rot.im;
		for (int i = 3; i < `MRD_LANES; i++) begin
			dout[i] <= '0;
		end
	end

endmodule

//--- source/mrd_dft_rdx4.sv
`include "mrd_dft_macros.svh"

module mrd_dft_rdx4 import mrd_dft_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  cplx_vec_t din,
	output logic      out_val,
	output cplx_vec_t dout
);

	logic [1:0] val_r;

	// stage 1 partial sums
	cplx_t s1_ac_sum;
	cplx_t s1_ac_dif;
	cplx_t s1_bd_sum;
	cplx_t s1_bd_dif;

	// stage 2
	cplx_t s2_x0;
	cplx_t s2_x2;
	cplx_t s2_u;
	cplx_t s2_mjv;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_r   <= 2'b00;
			out_val <= 1'b0;
		end else begin
			val_r[0] <= in_val;
			val_r[1] <= val_r[0];
			out_val  <= val_r[1];
		end
	end

	always_ff @(posedge clk) begin
		// stage 1: u = a - c, v = b - d
		s1_ac_sum.re <= din[0].re + din[2].re;
		s1_ac_sum.im <= din[0].im + din[2].im;
		s1_ac_dif.re <= din[0].re - din[2].re;
		s1_ac_dif.im <= din[0].im - din[2].im;
		s1_bd_sum.re <= din[1].re + din[3].re;
		s1_bd_sum.im <= din[1].im + din[3].im;
		s1_bd_dif.re <= din[1].re - din[3].re;
		s1_bd_dif.im <= din[1].im - din[3].im;

		// stage 2
		s2_x0.re <= s1_ac_sum.re + s1_bd_sum.re;
		s2_x0.im <= s1_ac_sum.im + s1_bd_sum.im;
		s2_x2.re <= s1_ac_sum.re - s1_bd_sum.re;
		s2_x2.im <= s1_ac_sum.im - s1_bd_sum.im;
		s2_u     <= s1_ac_dif;
		// -j*v is a swap plus one negation, no multiplier
		s2_mjv.re <= s1_bd_dif.im;
		s2_mjv.im <= -s1_bd_dif.re;

		// stage 3: X1 = u - j*v, X3 = u + j*v
		dout[0]    <= s2_x0;
		dout[1].re <= s2_u.re + s2_mjv.re;
		dout[1].im <= s2_u.im + s2_mjv.im;
		dout[2]    <= s2_x2;
		dout[3].re <= s2_u.re - s2_mjv.re;
		dout[3].im <= s2_u.im - s2_mjv.im;
		for (int i = 4; i < `MRD_LANES; i++) begin
			dout[i] <= '0;
		end
	end

endmodule

//--- source/mrd_dft_top.sv
module mrd_dft_top import mrd_dft_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  cplx_vec_t din,
	input  logic      cfg_wr,
	input  radix_t    cfg_radix,
	output logic      out_val,
	output cplx_vec_t dout,
	output radix_t    cur_radix
);

	radix_t radix;
	logic   pipe_empty;

	mrd_dft_cfg u_cfg (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_radix (cfg_radix),
		.pipe_empty(pipe_empty),
		.radix     (radix)
	);

	mrd_dft_core u_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.radix     (radix),
		.in_val    (in_val),
		.din       (din),
		.out_val   (out_val),
		.dout      (dout),
		.pipe_empty(pipe_empty)
	);

	assign cur_radix = radix;

endmodule

//--- tests/mrd_dft_tb.sv
`include "mrd_dft_macros.svh"

module mrd_dft_tb import mrd_dft_pkg::*; ();

	localparam int drive_dly = 10;

	// one expected result and the cycle it must show up in
	typedef struct packed {
		int        due;
		cplx_vec_t vec;
	} exp_entry_t;

	logic      clk;
	logic      rst_n;
	logic      in_val;
	cplx_vec_t din;
	logic      cfg_wr;
	radix_t    cfg_radix;
	logic      out_val;
	cplx_vec_t dout;
	radix_t    cur_radix;

	exp_entry_t  exp_q[$];
	exp_entry_t  head;
	logic        exp_val;
	cplx_vec_t   exp_vec;
	radix_t      exp_radix;
	radix_t      pend_radix;
	logic        pend;
	int          cyc;
	int          busy_until;
	logic [31:0] lcg_state;
	string       test_name;
	int          mismatch_cnt;
	int          other_cnt;

	mrd_dft_top uut (
		.clk(clk), .rst_n(rst_n), .in_val(in_val), .din(din), .cfg_wr(cfg_wr),
		.cfg_radix(cfg_radix), .out_val(out_val), .dout(dout), .cur_radix(cur_radix)
	);

	always #50 clk = ~clk;

	function automatic logic signed [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// all lanes random, so lanes above the radix prove they are ignored
	function automatic cplx_vec_t random_vector();
		cplx_vec_t v;
		for (int i = 0; i < `MRD_LANES; i++) begin
			v[i].re = next_rand();
			v[i].im = next_rand();
		end
		return v;
	endfunction

	function automatic cplx_vec_t model_vector(input radix_t rdx, input cplx_vec_t x);
		cplx_vec_t y;
		longint    xr[0:3];
		longint    xi[0:3];
		longint    yr[0:4];
		longint    yi[0:4];
		longint    s_re, s_im, t_re, t_im;
		longint    m_re, m_im, r_re, r_im;
		for (int i = 0; i < 4; i++) begin
			xr[i] = longint'(signed'(x[i].re));
			xi[i] = longint'(signed'(x[i].im));
		end
		for (int i = 0; i < `MRD_LANES; i++) begin
			yr[i] = 0;
			yi[i] = 0;
		end
		case (rdx)
			RDX_2: begin
				yr[0] = xr[0] + xr[1];
				yi[0] = xi[0] + xi[1];
				yr[1] = xr[0] - xr[1];
				yi[1] = xi[0] - xi[1];
			end
			RDX_4: begin
				yr[0] = xr[0] + xr[1] + xr[2] + xr[3];
				yi[0] = xi[0] + xi[1] + xi[2] + xi[3];
				// u - j*v, then (a+c) - (b+d), then u + j*v
				yr[1] = (xr[0] - xr[2]) + (xi[1] - xi[3]);
				yi[1] = (xi[0] - xi[2]) - (xr[1] - xr[3]);
				yr[2] = (xr[0] + xr[2]) - (xr[1] + xr[3]);
				yi[2] = (xi[0] + xi[2]) - (xi[1] + xi[3]);
				yr[3] = (xr[0] - xr[2]) - (xi[1] - xi[3]);
				yi[3] = (xi[0] - xi[2]) + (xr[1] - xr[3]);
			end
			default: begin
				s_re = xr[1] + xr[2];
				s_im = xi[1] + xi[2];
				t_re = xr[2] - xr[1];
				t_im = xi[2] - xi[1];
				// half of s, rounded toward zero
				m_re = xr[0] - s_re / 2;
				m_im = xi[0] - s_im / 2;
				r_re = (t_im * (-`MRD_C3_Q14)) >>> `MRD_C3_SHIFT;
				r_im = (t_re * `MRD_C3_Q14) >>> `MRD_C3_SHIFT;
				yr[0] = xr[0] + s_re;
				yi[0] = xi[0] + s_im;
				yr[1] = m_re + r_re;
				yi[1] = m_im + r_im;
				yr[2] = m_re - r_re;
				yi[2] = m_im - r_im;
			end
		endcase
		for (int i = 0; i < `MRD_LANES; i++) begin
			y[i].re = yr[i][`MRD_W_DATA-1:0];
			y[i].im = yi[i][`MRD_W_DATA-1:0];
		end
		return y;
	endfunction

	// expected outputs and applied radix for the edge just taken
	always @(posedge clk) begin
		cyc = cyc + 1;
		exp_val = 1'b0;
		if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			head = exp_q.pop_front();
			exp_val = 1'b1;
			exp_vec = head.vec;
		end
		if (pend && cyc > busy_until) begin
			exp_radix = pend_radix;
			pend = 1'b0;
		end
	end

	a_out_val: assert property (@(negedge clk) disable iff (!rst_n) out_val == exp_val)
	else begin
		mismatch_cnt++;
		$display("MISMATCH %s out_val expected %0b actual %0b", test_name, exp_val, out_val);
	end

	a_dout: assert property (@(negedge clk) disable iff (!rst_n) out_val |-> dout == exp_vec)
	else begin
		mismatch_cnt++;
		$display("MISMATCH %s dout expected %h actual %h", test_name, exp_vec, dout);
	end

	a_radix: assert property (@(negedge clk) disable iff (!rst_n) cur_radix == exp_radix)
	else begin
		mismatch_cnt++;
		$display("MISMATCH %s cur_radix expected %0d actual %0d", test_name, exp_radix,
			cur_radix);
	end

	task automatic next_cycle();
		@(posedge clk);
		#drive_dly;
	endtask

	task automatic send_vector(input cplx_vec_t v);
		exp_entry_t e;
		in_val = 1'b1;
		din = v;
		e.due = cyc + 4;
		e.vec = model_vector(exp_radix, v);
		exp_q.push_back(e);
		// last edge at which this vector still keeps the pipeline busy
		busy_until = cyc + 5;
		next_cycle();
		in_val = 1'b0;
	endtask

	task automatic write_radix(input radix_t r);
		cfg_wr = 1'b1;
		cfg_radix = r;
		pend = 1'b1;
		pend_radix = r;
		next_cycle();
		cfg_wr = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || out_val) && n < 50) begin
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0 || out_val) begin
			other_cnt++;
			$display("timeout in %s: results still pending after %0d cycles", test_name, n);
		end
	endtask

	task automatic wait_radix(input radix_t r);
		int n;
		n = 0;
		while (cur_radix != r && n < 20) begin
			next_cycle();
			n++;
		end
		if (cur_radix != r) begin
			other_cnt++;
			$display("timeout in %s: radix %0d was never applied", test_name, r);
		end
	endtask

	initial begin
		cplx_vec_t v;
		clk = 1'b0;
		rst_n = 1'b0;
		in_val = 1'b0;
		din = '0;
		cfg_wr = 1'b0;
		cfg_radix = RDX_3;
		exp_val = 1'b0;
		exp_vec = '0;
		exp_radix = RDX_3;
		pend_radix = RDX_3;
		pend = 1'b0;
		cyc = 0;
		busy_until = 0;
		lcg_state = 32'd51293;
		mismatch_cnt = 0;
		other_cnt = 0;

		test_name = "reset";
		repeat (4) next_cycle();
		rst_n = 1'b1;
		@(negedge clk);
		assert (!out_val && dout == '0) else begin
			mismatch_cnt++;
			$display("MISMATCH %s out_val/dout expected 0/0 actual %0b/%h", test_name,
				out_val, dout);
		end

		// b and c chosen so both parts of t are negative
		test_name = "radix3_stream";
		v = '0;
		v[0].re = 100;
		v[0].im = -50;
		v[1].re = 1000;
		v[1].im = 7;
		v[2].re = -3;
		v[2].im = -1001;
		v[3].re = 5;
		v[4].im = 6;
		next_cycle();
		send_vector(v);
		repeat (12) send_vector(random_vector());
		wait_drained();

		test_name = "radix2_stream";
		write_radix(RDX_2);
		repeat (10) send_vector(random_vector());
		wait_drained();

		test_name = "radix4_stream";
		write_radix(RDX_4);
		repeat (10) send_vector(random_vector());
		wait_drained();

		// write lands with vectors in flight and more still arriving
		test_name = "switch_in_flight";
		repeat (3) send_vector(random_vector());
		write_radix(RDX_2);
		repeat (2) send_vector(random_vector());
		wait_radix(RDX_2);
		repeat (4) send_vector(random_vector());
		wait_drained();

		test_name = "gapped_valid";
		write_radix(RDX_3);
		repeat (40) begin
			if (next_rand() > 0) begin
				send_vector(random_vector());
			end else begin
				next_cycle();
			end
		end
		wait_drained();
		repeat (3) next_cycle();

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
